// ==== bench/tb_tetris.sv ====
`timescale 1ns/100ps

module tb_tetris
    import tetris_pkg::*;
;

    localparam int NUM_TESTS   = 12;
    localparam int MAX_SPAWNS  = 6;
    localparam int LAND_OVER   = -1;
    localparam int READY_LIMIT = 60;
    localparam int STEP_LIMIT  = 30;

    logic        clk;
    logic        rst;
    logic        spawn_valid;
    piece_kind_t spawn_kind;
    col_idx_t    spawn_col;
    logic        step;
    row_idx_t    rd_row;
    logic        spawn_ready;
    row_bits_t   rd_bits;
    logic        landed;
    row_idx_t    land_row;
    line_count_t lines;
    logic        game_over;

    // stimulus and expected results, one entry per test
    string       tab_name  [NUM_TESTS];
    int          tab_idle  [NUM_TESTS];
    int          tab_lines [NUM_TESTS];
    logic        tab_over  [NUM_TESTS];
    row_bits_t   tab_r18   [NUM_TESTS];
    row_bits_t   tab_r19   [NUM_TESTS];
    int          tab_count [NUM_TESTS];
    piece_kind_t tab_kind  [NUM_TESTS][MAX_SPAWNS];
    col_idx_t    tab_col   [NUM_TESTS][MAX_SPAWNS];
    int          tab_land  [NUM_TESTS][MAX_SPAWNS];

    string cur_name;
    int    test_errors;
    int    errors_total;
    int    tests_failed;

    tetris_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .spawn_valid (spawn_valid),
        .spawn_kind  (spawn_kind),
        .spawn_col   (spawn_col),
        .step        (step),
        .rd_row      (rd_row),
        .spawn_ready (spawn_ready),
        .rd_bits     (rd_bits),
        .landed      (landed),
        .land_row    (land_row),
        .lines       (lines),
        .game_over   (game_over)
    );

    always #4 clk = ~clk;

    task automatic define_test(input int t, input string name, input int idle,
                               input int exp_lines, input logic exp_over,
                               input row_bits_t r18, input row_bits_t r19);
        tab_name[t]  = name;
        tab_idle[t]  = idle;
        tab_lines[t] = exp_lines;
        tab_over[t]  = exp_over;
        tab_r18[t]   = r18;
        tab_r19[t]   = r19;
        tab_count[t] = 0;
    endtask

    task automatic add_spawn(input int t, input piece_kind_t kind, input col_idx_t col,
                             input int land);
        tab_kind[t][tab_count[t]] = kind;
        tab_col[t][tab_count[t]]  = col;
        tab_land[t][tab_count[t]] = land;
        tab_count[t]++;
    endtask

    // landing rows and bottom rows worked out by hand from the shape table
    task automatic build_table();
        define_test(0, "line_alone", 0, 0, 1'b0, 10'h001, 10'h001);
        add_spawn(0, KIND_LINE, 4'd0, 16);
        define_test(1, "square_alone", 0, 0, 1'b0, 10'h300, 10'h300);
        add_spawn(1, KIND_SQUARE, 4'd8, 18);
        define_test(2, "l_alone", 0, 0, 1'b0, 10'h004, 10'h00c);
        add_spawn(2, KIND_L, 4'd2, 17);
        define_test(3, "rev_l_alone", 0, 0, 1'b0, 10'h080, 10'h0c0);
        add_spawn(3, KIND_REV_L, 4'd6, 17);
        define_test(4, "s_alone", 0, 0, 1'b0, 10'h030, 10'h018);
        add_spawn(4, KIND_S, 4'd3, 18);
        define_test(5, "z_alone", 0, 0, 1'b0, 10'h180, 10'h300);
        add_spawn(5, KIND_Z, 4'd7, 18);
        define_test(6, "t_alone", 0, 0, 1'b0, 10'h002, 10'h007);
        add_spawn(6, KIND_T, 4'd0, 18);
        define_test(7, "square_on_square", 0, 0, 1'b0, 10'h030, 10'h030);
        add_spawn(7, KIND_SQUARE, 4'd4, 18);
        add_spawn(7, KIND_SQUARE, 4'd4, 16);
        // three T pieces and a line fill row 19 only
        define_test(8, "single_clear", 0, 1, 1'b0, 10'h200, 10'h292);
        add_spawn(8, KIND_T, 4'd0, 18);
        add_spawn(8, KIND_T, 4'd3, 18);
        add_spawn(8, KIND_T, 4'd6, 18);
        add_spawn(8, KIND_LINE, 4'd9, 16);
        define_test(9, "double_clear", 0, 2, 1'b0, 10'h300, 10'h300);
        add_spawn(9, KIND_SQUARE, 4'd0, 18);
        add_spawn(9, KIND_SQUARE, 4'd2, 18);
        add_spawn(9, KIND_SQUARE, 4'd4, 18);
        add_spawn(9, KIND_SQUARE, 4'd6, 18);
        add_spawn(9, KIND_LINE, 4'd8, 16);
        add_spawn(9, KIND_LINE, 4'd9, 16);
        define_test(10, "stack_to_top", 0, 0, 1'b1, 10'h001, 10'h001);
        add_spawn(10, KIND_LINE, 4'd0, 16);
        add_spawn(10, KIND_LINE, 4'd0, 12);
        add_spawn(10, KIND_LINE, 4'd0, 8);
        add_spawn(10, KIND_LINE, 4'd0, 4);
        add_spawn(10, KIND_LINE, 4'd0, 0);
        add_spawn(10, KIND_LINE, 4'd0, LAND_OVER);
        // columns 15 and 13 clamp to 8 and 7
        define_test(11, "idle_step_clamp", 3, 0, 1'b0, 10'h300, 10'h300);
        add_spawn(11, KIND_SQUARE, 4'd15, 18);
        add_spawn(11, KIND_T, 4'd13, 16);
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("Mismatch in %s: %s expected 0x%0h, actual 0x%0h",
                     cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic wait_spawn_ready(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < READY_LIMIT && !ok; n++) begin
            if (spawn_ready) ok = 1'b1;
            else wait_cycle();
        end
        assert (ok) else begin
            $display("Error in %s: spawn_ready did not rise within %0d cycles",
                     cur_name, READY_LIMIT);
            test_errors++;
        end
    endtask

    // one step pulse, then a quiet cycle in which landed would show
    task automatic step_until_landed(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < STEP_LIMIT && !ok; n++) begin
            step = 1'b1;
            wait_cycle();
            step = 1'b0;
            wait_cycle();
            if (landed) ok = 1'b1;
        end
        assert (ok) else begin
            $display("Error in %s: piece did not land after %0d steps", cur_name, STEP_LIMIT);
            test_errors++;
        end
    endtask

    task automatic send_spawn(input piece_kind_t kind, input col_idx_t col);
        spawn_kind  = kind;
        spawn_col   = col;
        spawn_valid = 1'b1;
        wait_cycle();
        spawn_valid = 1'b0;
    endtask

    task automatic read_row(input row_idx_t row, output row_bits_t bits);
        rd_row = row;
        #1;
        bits = rd_bits;
    endtask

    task automatic run_test(input int t);
        bit        ok;
        row_bits_t bits;
        int        s;
        cur_name    = tab_name[t];
        test_errors = 0;
        apply_reset();
        repeat (tab_idle[t]) begin
            step = 1'b1;
            wait_cycle();
            step = 1'b0;
            wait_cycle();
            check_value("spawn_ready after idle step", 1, spawn_ready);
            check_value("landed after idle step", 0, landed);
        end
        ok = 1'b1;
        for (s = 0; s < tab_count[t] && ok; s++) begin
            wait_spawn_ready(ok);
            if (ok) begin
                send_spawn(tab_kind[t][s], tab_col[t][s]);
                if (tab_land[t][s] == LAND_OVER) begin
                    check_value("game_over after blocked spawn", 1, game_over);
                    check_value("spawn_ready after blocked spawn", 0, spawn_ready);
                    // game over must hold
                    repeat (4) wait_cycle();
                    check_value("game_over held", 1, game_over);
                    check_value("spawn_ready held low", 0, spawn_ready);
                end else begin
                    step_until_landed(ok);
                    if (ok) begin
                        check_value($sformatf("land_row of spawn %0d", s),
                                    tab_land[t][s], land_row);
                    end
                end
            end
        end
        if (ok && !tab_over[t]) wait_spawn_ready(ok);
        check_value("lines", tab_lines[t], lines);
        check_value("game_over", tab_over[t], game_over);
        read_row(5'd18, bits);
        check_value("row 18", tab_r18[t], bits);
        read_row(5'd19, bits);
        check_value("row 19", tab_r19[t], bits);
        if (test_errors == 0) begin
            $display("test %s: ok", cur_name);
        end else begin
            $display("test %s: %0d errors", cur_name, test_errors);
            tests_failed++;
        end
        errors_total += test_errors;
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        spawn_valid  = 1'b0;
        spawn_kind   = '0;
        spawn_col    = '0;
        step         = 1'b0;
        rd_row       = '0;
        errors_total = 0;
        tests_failed = 0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, errors_total);
        if (errors_total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== board/board_store.sv ====
`timescale 1ns/100ps

module board_store
    import tetris_pkg::*;
#(
    parameter int ROWS = BOARD_ROWS,
    parameter int COLS = BOARD_COLS
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      merge,
    input  row_idx_t  cell_row0,
    input  row_idx_t  cell_row1,
    input  row_idx_t  cell_row2,
    input  row_idx_t  cell_row3,
    input  col_idx_t  cell_col0,
    input  col_idx_t  cell_col1,
    input  col_idx_t  cell_col2,
    input  col_idx_t  cell_col3,
    input  row_idx_t  probe_row,
    output logic      board_hit,
    input  logic      shift_en,
    input  row_idx_t  shift_row,
    input  row_idx_t  rd_row,
    output row_bits_t rd_bits,
    input  row_idx_t  test_row,
    output logic      test_full
);

    row_bits_t rows [ROWS];
    row_idx_t  cr [4];
    col_idx_t  cc [4];

    assign cr = '{cell_row0, cell_row1, cell_row2, cell_row3};
    assign cc = '{cell_col0, cell_col1, cell_col2, cell_col3};

    // cells shifted down by the probe offset, rows past the floor skipped
    always_comb begin
        row_idx_t pr;
        board_hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            pr = cr[i] + probe_row;
            if (int'(pr) < ROWS && rows[pr][cc[i]]) begin
                board_hit = 1'b1;
            end
        end
    end

    assign rd_bits   = (int'(rd_row) < ROWS) ? rows[rd_row] : '0;
    assign test_full = (int'(test_row) < ROWS) && (&rows[test_row][COLS-1:0]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < ROWS; r++) begin
                rows[r] <= '0;
            end
        end else if (merge) begin
            for (int i = 0; i < 4; i++) begin
                if (int'(cr[i]) < ROWS) begin
                    rows[cr[i]][cc[i]] <= 1'b1;
                end
            end
        end else if (shift_en) begin
            // drop everything above the removed row by one
            for (int r = ROWS - 1; r > 0; r--) begin
                if (r <= int'(shift_row)) begin
                    rows[r] <= rows[r-1];
                end
            end
            rows[0] <= '0;
        end
    end

    a_merge_shift_apart: assert property (
        @(posedge clk) disable iff (rst) !(merge && shift_en)
    );

endmodule

// ==== board/line_clear.sv ====
`timescale 1ns/100ps

module line_clear
    import tetris_pkg::*;
#(
    parameter int ROWS = BOARD_ROWS
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       test_full,
    output row_idx_t   test_row,
    output logic       shift_en,
    output row_idx_t   shift_row,
    output logic       clear_done,
    output logic [2:0] cleared_n
);

    clear_state_t state;
    row_idx_t     row_q;
    logic [2:0]   count;

    // bottom up walk, a full row is shifted out and the same index tested again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DONE;
            row_q <= '0;
            count <= '0;
        end else begin
            case (state)
                DONE: begin
                    if (start) begin
                        state <= SCAN;
                        row_q <= row_idx_t'(ROWS - 1);
                        count <= '0;
                    end
                end
                SCAN: begin
                    if (test_full) begin
                        state <= SHIFT;
                    end else if (row_q == '0) begin
                        state <= DONE;
                    end else begin
                        row_q <= row_q - 5'd1;
                    end
                end
                SHIFT: begin
                    count <= count + 3'd1;
                    state <= SCAN;
                end
                default: begin
                    state <= DONE;
                end
            endcase
        end
    end

    assign test_row   = row_q;
    assign shift_row  = row_q;
    assign shift_en   = (state == SHIFT);
    // top row checked and not full, scan is over
    assign clear_done = (state == SCAN) && !test_full && (row_q == '0);
    assign cleared_n  = count;

endmodule

// ==== common/tetris_pkg.sv ====
package tetris_pkg;

    // default board size, top level passes these down as ROWS and COLS
    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;

    // one board row, column 0 in bit 0
    typedef logic [BOARD_COLS-1:0] row_bits_t;
    typedef logic [4:0]            row_idx_t;
    typedef logic [3:0]            col_idx_t;
    typedef logic [15:0]           line_count_t;
    typedef logic [2:0]            piece_kind_t;

    // piece kinds
    localparam piece_kind_t KIND_LINE    = 3'd0;
    localparam piece_kind_t KIND_SQUARE  = 3'd1;
    localparam piece_kind_t KIND_L       = 3'd2;
    localparam piece_kind_t KIND_REV_L   = 3'd3;
    localparam piece_kind_t KIND_S       = 3'd4;
    localparam piece_kind_t KIND_Z       = 3'd5;
    localparam piece_kind_t KIND_T       = 3'd6;
    // not a piece, refused at spawn
    localparam piece_kind_t KIND_INVALID = 3'd7;

    typedef enum logic [2:0] {
        IDLE,
        FALL,
        MERGE,
        CLEAR,
        OVER
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SCAN,
        SHIFT,
        DONE
    } clear_state_t;

endpackage

// ==== piece/piece_drop.sv ====
`timescale 1ns/100ps

module piece_drop
    import tetris_pkg::*;
#(
    parameter int ROWS = BOARD_ROWS,
    parameter int COLS = BOARD_COLS
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  piece_kind_t kind,
    input  col_idx_t    col,
    input  logic        step_en,
    input  logic        board_hit,
    output row_idx_t    probe_row,
    output row_idx_t    cell_row0,
    output row_idx_t    cell_row1,
    output row_idx_t    cell_row2,
    output row_idx_t    cell_row3,
    output col_idx_t    cell_col0,
    output col_idx_t    cell_col1,
    output col_idx_t    cell_col2,
    output col_idx_t    cell_col3,
    output logic        blocked,
    output logic        lock,
    output row_idx_t    land_row
);

    piece_kind_t kind_q;
    piece_kind_t shape_kind;
    col_idx_t    col_q;
    col_idx_t    shape_col;
    row_idx_t    row_q;
    row_idx_t    base_row;
    row_idx_t    dr0, dr1, dr2, dr3;
    logic        floor_hit;
    logic        bad_kind;

    // while loading, look at the requested piece placed at the top
    assign shape_kind = load ? kind : kind_q;
    assign shape_col  = load ? col : col_q;
    assign base_row   = load ? row_idx_t'(0) : row_q;

    piece_shape #(
        .COLS (COLS)
    ) u_shape (
        .kind (shape_kind),
        .col  (shape_col),
        .dr0  (dr0),
        .dr1  (dr1),
        .dr2  (dr2),
        .dr3  (dr3),
        .c0   (cell_col0),
        .c1   (cell_col1),
        .c2   (cell_col2),
        .c3   (cell_col3)
    );

    assign cell_row0 = base_row + dr0;
    assign cell_row1 = base_row + dr1;
    assign cell_row2 = base_row + dr2;
    assign cell_row3 = base_row + dr3;

    // probe offset 0 tests the spawn cells and 1 tests one row lower
    assign probe_row = load ? row_idx_t'(0) : row_idx_t'(1);

    // floor test for cells pushed past the last row
    always_comb begin
        floor_hit = 1'b0;
        if (int'(cell_row0) + int'(probe_row) >= ROWS) floor_hit = 1'b1;
        if (int'(cell_row1) + int'(probe_row) >= ROWS) floor_hit = 1'b1;
        if (int'(cell_row2) + int'(probe_row) >= ROWS) floor_hit = 1'b1;
        if (int'(cell_row3) + int'(probe_row) >= ROWS) floor_hit = 1'b1;
    end

    // an invalid kind reads as a blocked spawn
    assign bad_kind = load && (kind == KIND_INVALID);
    assign blocked  = board_hit || floor_hit || bad_kind;

    always_ff @(posedge clk) begin
        if (load) begin
            kind_q <= kind;
            col_q  <= col;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_q    <= '0;
            lock     <= 1'b0;
            land_row <= '0;
        end else begin
            lock <= 1'b0;
            if (load) begin
                row_q <= '0;
            end else if (step_en) begin
                if (blocked) begin
                    lock     <= 1'b1;
                    land_row <= row_q;
                end else begin
                    row_q <= row_q + 5'd1;
                end
            end
        end
    end

    // a lock stays in FALL with no new spawn and no second step
    a_lock_in_fall: assert property (
        @(posedge clk) disable iff (rst) lock |-> !load && !step_en
    );

endmodule

// ==== piece/piece_shape.sv ====
`timescale 1ns/100ps

module piece_shape
    import tetris_pkg::*;
#(
    parameter int COLS = BOARD_COLS
) (
    input  piece_kind_t kind,
    input  col_idx_t    col,
    output row_idx_t    dr0,
    output row_idx_t    dr1,
    output row_idx_t    dr2,
    output row_idx_t    dr3,
    output col_idx_t    c0,
    output col_idx_t    c1,
    output col_idx_t    c2,
    output col_idx_t    c3
);

    col_idx_t oc0, oc1, oc2, oc3;
    col_idx_t width;
    col_idx_t max_left;
    col_idx_t left;

    // fixed orientation, offsets as (row, col) from the top left
    always_comb begin
        dr0 = '0;
        dr1 = '0;
        dr2 = '0;
        dr3 = '0;
        oc0 = '0;
        oc1 = '0;
        oc2 = '0;
        oc3 = '0;
        width = 4'd1;
        case (kind)
            KIND_LINE: begin
                dr1 = 5'd1;
                dr2 = 5'd2;
                dr3 = 5'd3;
            end
            KIND_SQUARE: begin
                dr2 = 5'd1;
                dr3 = 5'd1;
                oc1 = 4'd1;
                oc3 = 4'd1;
                width = 4'd2;
            end
            KIND_L: begin
                dr1 = 5'd1;
                dr2 = 5'd2;
                dr3 = 5'd2;
                oc3 = 4'd1;
                width = 4'd2;
            end
            KIND_REV_L: begin
                dr1 = 5'd1;
                dr2 = 5'd2;
                dr3 = 5'd2;
                oc0 = 4'd1;
                oc1 = 4'd1;
                oc2 = 4'd1;
                width = 4'd2;
            end
            KIND_S: begin
                dr2 = 5'd1;
                dr3 = 5'd1;
                oc0 = 4'd1;
                oc1 = 4'd2;
                oc3 = 4'd1;
                width = 4'd3;
            end
            KIND_Z: begin
                dr2 = 5'd1;
                dr3 = 5'd1;
                oc1 = 4'd1;
                oc2 = 4'd1;
                oc3 = 4'd2;
                width = 4'd3;
            end
            KIND_T: begin
                dr1 = 5'd1;
                dr2 = 5'd1;
                dr3 = 5'd1;
                oc0 = 4'd1;
                oc2 = 4'd1;
                oc3 = 4'd2;
                width = 4'd3;
            end
            default: begin
                // all four cells on (0,0)
            end
        endcase
    end

    // clamp so the rightmost cell stays on the board
    assign max_left = col_idx_t'(COLS) - width;
    assign left     = (col > max_left) ? max_left : col;

    assign c0 = left + oc0;
    assign c1 = left + oc1;
    assign c2 = left + oc2;
    assign c3 = left + oc3;

endmodule

// ==== sim.f ====
common/tetris_pkg.sv
piece/piece_shape.sv
piece/piece_drop.sv
board/board_store.sv
board/line_clear.sv
source/game_ctrl.sv
source/tetris_top.sv
bench/tb_tetris.sv

// ==== source/game_ctrl.sv ====
`timescale 1ns/100ps

module game_ctrl
    import tetris_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        spawn_valid,
    output logic        spawn_ready,
    input  logic        spawn_hit,
    input  logic        step,
    input  logic        lock,
    output logic        load,
    output logic        step_en,
    output logic        merge,
    output logic        clear_start,
    input  logic        clear_done,
    input  logic [2:0]  cleared_n,
    output logic        landed,
    output line_count_t lines,
    output logic        game_over
);

    ctrl_state_t state;
    ctrl_state_t state_n;

    always_comb begin
        state_n = state;
        case (state)
            IDLE: begin
                if (spawn_valid) begin
                    state_n = spawn_hit ? OVER : FALL;
                end
            end
            FALL: begin
                if (lock) begin
                    state_n = MERGE;
                end
            end
            MERGE: state_n = CLEAR;
            CLEAR: begin
                if (clear_done) begin
                    state_n = IDLE;
                end
            end
            OVER: state_n = OVER;
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            landed <= 1'b0;
            lines  <= '0;
        end else begin
            state  <= state_n;
            landed <= (state == FALL) && lock;
            if (state == CLEAR && clear_done) begin
                lines <= lines + line_count_t'(cleared_n);
            end
        end
    end

    assign spawn_ready = (state == IDLE);
    assign load        = spawn_ready && spawn_valid;
    // steps wait out the lock cycle so a piece locks only once
    assign step_en     = (state == FALL) && step && !lock;
    assign merge       = (state == MERGE);
    assign clear_start = merge;
    assign game_over   = (state == OVER);

    // landing pulse lines up with the move from FALL into MERGE
    a_landed_from_fall: assert property (
        @(posedge clk) disable iff (rst) landed |-> (state == MERGE) && ($past(state) == FALL)
    );

endmodule

// ==== source/tetris_top.sv ====
`timescale 1ns/100ps

module tetris_top
    import tetris_pkg::*;
#(
    parameter int ROWS = BOARD_ROWS,
    parameter int COLS = BOARD_COLS
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        spawn_valid,
    input  piece_kind_t spawn_kind,
    input  col_idx_t    spawn_col,
    input  logic        step,
    input  row_idx_t    rd_row,
    output logic        spawn_ready,
    output row_bits_t   rd_bits,
    output logic        landed,
    output row_idx_t    land_row,
    output line_count_t lines,
    output logic        game_over
);

    logic       load, step_en, lock, blocked, board_hit;
    logic       merge, clear_start, clear_done;
    logic       shift_en, test_full;
    logic [2:0] cleared_n;
    row_idx_t   probe_row, shift_row, test_row;
    row_idx_t   cell_row0, cell_row1, cell_row2, cell_row3;
    col_idx_t   cell_col0, cell_col1, cell_col2, cell_col3;

    game_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .spawn_valid (spawn_valid),
        .spawn_ready (spawn_ready),
        .spawn_hit   (blocked),
        .step        (step),
        .lock        (lock),
        .load        (load),
        .step_en     (step_en),
        .merge       (merge),
        .clear_start (clear_start),
        .clear_done  (clear_done),
        .cleared_n   (cleared_n),
        .landed      (landed),
        .lines       (lines),
        .game_over   (game_over)
    );

    piece_drop #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_drop (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .kind      (spawn_kind),
        .col       (spawn_col),
        .step_en   (step_en),
        .board_hit (board_hit),
        .probe_row (probe_row),
        .cell_row0 (cell_row0), .cell_row1 (cell_row1),
        .cell_row2 (cell_row2), .cell_row3 (cell_row3),
        .cell_col0 (cell_col0), .cell_col1 (cell_col1),
        .cell_col2 (cell_col2), .cell_col3 (cell_col3),
        .blocked   (blocked),
        .lock      (lock),
        .land_row  (land_row)
    );

    board_store #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_board (
        .clk       (clk),
        .rst       (rst),
        .merge     (merge),
        .cell_row0 (cell_row0), .cell_row1 (cell_row1),
        .cell_row2 (cell_row2), .cell_row3 (cell_row3),
        .cell_col0 (cell_col0), .cell_col1 (cell_col1),
        .cell_col2 (cell_col2), .cell_col3 (cell_col3),
        .probe_row (probe_row),
        .board_hit (board_hit),
        .shift_en  (shift_en),
        .shift_row (shift_row),
        .rd_row    (rd_row),
        .rd_bits   (rd_bits),
        .test_row  (test_row),
        .test_full (test_full)
    );

    line_clear #(
        .ROWS (ROWS)
    ) u_clear (
        .clk        (clk),
        .rst        (rst),
        .start      (clear_start),
        .test_full  (test_full),
        .test_row   (test_row),
        .shift_en   (shift_en),
        .shift_row  (shift_row),
        .clear_done (clear_done),
        .cleared_n  (cleared_n)
    );

endmodule
